/* Bender.yml */
package:
  name: sync_exchange

sources:
  - design/sync_pkg.sv
  - design/sync_reg.sv
  - design/sync_put_port.sv
  - design/sync_take_port.sv
  - design/sync_exchange_top.sv
  - target: test
    files:
      - dv/tb_sync_exchange.sv

/* design/sync_exchange_top.sv */
`timescale 1ns/10ps

module sync_exchange_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        put_valid_0,
  input  logic                        put_valid_1,
  input  logic [sync_pkg::data_w-1:0] put_data_0,
  input  logic [sync_pkg::data_w-1:0] put_data_1,
  input  logic                        take_req_0,
  input  logic                        take_req_1,
  output logic                        put_ready_0,
  output logic                        put_ready_1,
  output logic                        take_ready_0,
  output logic                        take_ready_1,
  output logic                        take_valid_0,
  output logic                        take_valid_1,
  output logic [sync_pkg::data_w-1:0] take_data_0,
  output logic [sync_pkg::data_w-1:0] take_data_1,
  output logic                        full
);

  // Writer side of the register
  logic [sync_pkg::data_w-1:0] in_0;
  logic [sync_pkg::data_w-1:0] in_1;
  logic                        write_en_0;
  logic                        write_en_1;
  logic                        write_done_0;
  logic                        write_done_1;

  // Reader side of the register
  logic [sync_pkg::data_w-1:0] out_0;
  logic [sync_pkg::data_w-1:0] out_1;
  logic                        read_en_0;
  logic                        read_en_1;
  logic                        read_done_0;
  logic                        read_done_1;

  sync_put_port i_put_0 (
    .clk        (clk),
    .reset      (reset),
    .put_valid  (put_valid_0),
    .put_data   (put_data_0),
    .write_done (write_done_0),
    .put_ready  (put_ready_0),
    .write_en   (write_en_0),
    .write_data (in_0)
  );

  sync_put_port i_put_1 (
    .clk        (clk),
    .reset      (reset),
    .put_valid  (put_valid_1),
    .put_data   (put_data_1),
    .write_done (write_done_1),
    .put_ready  (put_ready_1),
    .write_en   (write_en_1),
    .write_data (in_1)
  );

  sync_take_port i_take_0 (
    .clk        (clk),
    .reset      (reset),
    .take_req   (take_req_0),
    .read_done  (read_done_0),
    .read_data  (out_0),
    .take_ready (take_ready_0),
    .read_en    (read_en_0),
    .take_valid (take_valid_0),
    .take_data  (take_data_0)
  );

  sync_take_port i_take_1 (
    .clk        (clk),
    .reset      (reset),
    .take_req   (take_req_1),
    .read_done  (read_done_1),
    .read_data  (out_1),
    .take_ready (take_ready_1),
    .read_en    (read_en_1),
    .take_valid (take_valid_1),
    .take_data  (take_data_1)
  );

  // Single shared word between both sides
  sync_reg i_reg (
    .clk          (clk),
    .reset        (reset),
    .in_0         (in_0),
    .in_1         (in_1),
    .write_en_0   (write_en_0),
    .write_en_1   (write_en_1),
    .read_en_0    (read_en_0),
    .read_en_1    (read_en_1),
    .out_0        (out_0),
    .out_1        (out_1),
    .write_done_0 (write_done_0),
    .write_done_1 (write_done_1),
    .read_done_0  (read_done_0),
    .read_done_1  (read_done_1),
    .full         (full)
  );

endmodule

/* design/sync_pkg.sv */
package sync_pkg;

  // Width of every data word moving through the exchange
  localparam int data_w = 32;

  // Occupancy of the single-word M-structure register
  // A write is only accepted while empty, a read only while full
  typedef enum logic {
    slot_empty = 1'b0,
    slot_full  = 1'b1
  } slot_state_e;

  // State of a put or take adapter
  typedef enum logic {
    // Accepting a new strobe
    port_idle = 1'b0,
    // Enable held toward the register until its done pulse
    port_wait = 1'b1
  } port_state_e;

endpackage

/* design/sync_put_port.sv */
`timescale 1ns/10ps

module sync_put_port (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        put_valid,
  input  logic [sync_pkg::data_w-1:0] put_data,
  input  logic                        write_done,
  output logic                        put_ready,
  output logic                        write_en,
  output logic [sync_pkg::data_w-1:0] write_data
);

  sync_pkg::port_state_e       state;
  logic [sync_pkg::data_w-1:0] data_q;

  // Idle until a put, then wait for the register to take the word
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sync_pkg::port_idle;
    end else begin
      case (state)
        sync_pkg::port_idle: begin
          if (put_valid) begin
            state <= sync_pkg::port_wait;
          end
        end
        sync_pkg::port_wait: begin
          // Leave one edge after the done pulse
          if (write_done) begin
            state <= sync_pkg::port_idle;
          end
        end
        default: state <= sync_pkg::port_idle;
      endcase
    end
  end

  // Latch the word on an accepted put only
  always_ff @(posedge clk) begin
    if ((state == sync_pkg::port_idle) && put_valid) begin
      data_q <= put_data;
    end
  end

  assign put_ready  = (state == sync_pkg::port_idle);
  assign write_en   = (state == sync_pkg::port_wait);
  assign write_data = data_q;

  // Register needs the word steady for the whole write
  a_write_data_stable: assert property (
    @(posedge clk) disable iff (reset)
    write_en |=> !write_en || $stable(write_data));

endmodule

/* design/sync_reg.sv */
`timescale 1ns/10ps

module sync_reg (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [sync_pkg::data_w-1:0] in_0,
  input  logic [sync_pkg::data_w-1:0] in_1,
  input  logic                        write_en_0,
  input  logic                        write_en_1,
  input  logic                        read_en_0,
  input  logic                        read_en_1,
  output logic [sync_pkg::data_w-1:0] out_0,
  output logic [sync_pkg::data_w-1:0] out_1,
  output logic                        write_done_0,
  output logic                        write_done_1,
  output logic                        read_done_0,
  output logic                        read_done_1,
  output logic                        full
);

  // Slot occupancy and the stored word
  sync_pkg::slot_state_e       slot_state;
  logic [sync_pkg::data_w-1:0] data_q;

  // Round-robin bits, 0 favours client 0
  logic arb_w;
  logic arb_r;

  // Request decode against the slot state
  logic write_mult;
  logic read_mult;
  logic write_sel_0;
  logic write_sel_1;
  logic read_sel_0;
  logic read_sel_1;
  logic write_any;
  logic read_any;

  // Both writers asking onto an empty slot
  assign write_mult = (slot_state == sync_pkg::slot_empty) && write_en_0 && write_en_1;
  // Both readers asking from a full slot
  assign read_mult  = (slot_state == sync_pkg::slot_full) && read_en_0 && read_en_1;

  // Writer 0 wins when alone, or on contention with the arbiter at 0
  assign write_sel_0 = (slot_state == sync_pkg::slot_empty) && write_en_0 &&
                       (!write_en_1 || !arb_w);
  // Writer 1 wins when alone, or on contention with the arbiter at 1
  assign write_sel_1 = (slot_state == sync_pkg::slot_empty) && write_en_1 &&
                       (!write_en_0 || arb_w);

  // Same selection on the read side
  assign read_sel_0 = (slot_state == sync_pkg::slot_full) && read_en_0 &&
                      (!read_en_1 || !arb_r);
  assign read_sel_1 = (slot_state == sync_pkg::slot_full) && read_en_1 &&
                      (!read_en_0 || arb_r);

  assign write_any = write_sel_0 || write_sel_1;
  assign read_any  = read_sel_0 || read_sel_1;

  // Occupancy, a write and a read never commit together
  always_ff @(posedge clk) begin
    if (reset) begin
      slot_state <= sync_pkg::slot_empty;
    end else if (write_any) begin
      slot_state <= sync_pkg::slot_full;
    end else if (read_any) begin
      slot_state <= sync_pkg::slot_empty;
    end
  end

  // Arbiters flip only in cycles with contention
  always_ff @(posedge clk) begin
    if (reset) begin
      arb_w <= 1'b0;
      arb_r <= 1'b0;
    end else begin
      if (write_mult) begin
        arb_w <= !arb_w;
      end
      if (read_mult) begin
        arb_r <= !arb_r;
      end
    end
  end

  // Stored word, kept after a read
  always_ff @(posedge clk) begin
    if (reset) begin
      data_q <= '0;
    end else if (write_sel_0) begin
      data_q <= in_0;
    end else if (write_sel_1) begin
      data_q <= in_1;
    end
  end

  // Read outputs, only meaningful in their done cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      out_0 <= '0;
      out_1 <= '0;
    end else begin
      if (read_sel_0) begin
        out_0 <= data_q;
      end
      if (read_sel_1) begin
        out_1 <= data_q;
      end
    end
  end

  // One-cycle done pulses in the cycle after commit
  always_ff @(posedge clk) begin
    if (reset) begin
      write_done_0 <= 1'b0;
      write_done_1 <= 1'b0;
      read_done_0  <= 1'b0;
      read_done_1  <= 1'b0;
    end else begin
      write_done_0 <= write_sel_0;
      write_done_1 <= write_sel_1;
      read_done_0  <= read_sel_0;
      read_done_1  <= read_sel_1;
    end
  end

  assign full = (slot_state == sync_pkg::slot_full);

  // Client must keep the enable up until the done pulse
  property p_en_held(en, done);
    @(posedge clk) disable iff (reset) en && !done |=> en;
  endproperty

  a_write_sel_onehot: assert property (
    @(posedge clk) disable iff (reset) !(write_sel_0 && write_sel_1));
  a_read_sel_onehot: assert property (
    @(posedge clk) disable iff (reset) !(read_sel_0 && read_sel_1));

  a_write_en_0_held: assert property (p_en_held(write_en_0, write_done_0));
  a_write_en_1_held: assert property (p_en_held(write_en_1, write_done_1));

  // Slot is full and the winner is told in the cycle after a write
  a_write_0_commit: assert property (
    @(posedge clk) disable iff (reset) write_sel_0 |=> full && write_done_0);
  a_write_1_commit: assert property (
    @(posedge clk) disable iff (reset) write_sel_1 |=> full && write_done_1);

endmodule

/* design/sync_take_port.sv */
`timescale 1ns/10ps

module sync_take_port (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        take_req,
  input  logic                        read_done,
  input  logic [sync_pkg::data_w-1:0] read_data,
  output logic                        take_ready,
  output logic                        read_en,
  output logic                        take_valid,
  output logic [sync_pkg::data_w-1:0] take_data
);

  sync_pkg::port_state_e state;
  logic                  capture;

  // Read value from the register lives for this one cycle only
  assign capture = (state == sync_pkg::port_wait) && read_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sync_pkg::port_idle;
    end else begin
      case (state)
        sync_pkg::port_idle: begin
          if (take_req) begin
            state <= sync_pkg::port_wait;
          end
        end
        sync_pkg::port_wait: begin
          if (read_done) begin
            state <= sync_pkg::port_idle;
          end
        end
        default: state <= sync_pkg::port_idle;
      endcase
    end
  end

  // Valid pulse follows the capture by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      take_valid <= 1'b0;
      take_data  <= '0;
    end else begin
      take_valid <= capture;
      // Word is held until the next capture
      if (capture) begin
        take_data <= read_data;
      end
    end
  end

  assign take_ready = (state == sync_pkg::port_idle);
  assign read_en    = (state == sync_pkg::port_wait);

  // Register must only answer a read this port is waiting on
  a_done_only_when_waiting: assert property (
    @(posedge clk) disable iff (reset) read_done |-> state == sync_pkg::port_wait);

endmodule

/* dv/tb_sync_exchange.sv */
`timescale 1ns/10ps

module tb_sync_exchange;

  typedef enum logic [2:0] {
    op_put_0, op_put_1, op_put_both, op_take_0, op_take_1, op_take_both
  } op_e;

  // One table row
  // takes[n] is set when take port n must deliver a word in this row
  typedef struct packed {
    op_e                         op;
    logic                        rnd;
    logic [sync_pkg::data_w-1:0] d0;
    logic [sync_pkg::data_w-1:0] d1;
    logic [1:0]                  takes;
    logic                        full;
  } row_t;

  logic                        clk;
  logic                        reset;
  logic [1:0]                  put_valid;
  logic [1:0]                  take_req;
  logic [sync_pkg::data_w-1:0] put_data [2];
  wire  [1:0]                  put_ready;
  wire  [1:0]                  take_ready;
  wire  [1:0]                  take_valid;
  wire  [sync_pkg::data_w-1:0] take_data [2];
  wire                         full;

  row_t        table_q [$];
  logic [15:0] lfsr;

  // Scoreboard of slot content, arbiter bits and clients still waiting
  logic                        m_full;
  logic [sync_pkg::data_w-1:0] m_word;
  logic                        m_arb_w;
  logic                        m_arb_r;
  logic [1:0]                  pend_put;
  logic [1:0]                  pend_take;
  logic [sync_pkg::data_w-1:0] pend_data [2];
  logic [1:0]                  put_done;
  // Take ports that pulsed take_valid during the current row
  logic [1:0]                  got_takes;
  // Words each take port still has to deliver, oldest first
  logic [sync_pkg::data_w-1:0] exp_q0 [$];
  logic [sync_pkg::data_w-1:0] exp_q1 [$];

  sync_exchange_top i_dut (
    .clk          (clk),
    .reset        (reset),
    .put_valid_0  (put_valid[0]),
    .put_valid_1  (put_valid[1]),
    .put_data_0   (put_data[0]),
    .put_data_1   (put_data[1]),
    .take_req_0   (take_req[0]),
    .take_req_1   (take_req[1]),
    .put_ready_0  (put_ready[0]),
    .put_ready_1  (put_ready[1]),
    .take_ready_0 (take_ready[0]),
    .take_ready_1 (take_ready[1]),
    .take_valid_0 (take_valid[0]),
    .take_valid_1 (take_valid[1]),
    .take_data_0  (take_data[0]),
    .take_data_1  (take_data[1]),
    .full         (full)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic check_value(input logic [sync_pkg::data_w-1:0] actual,
                             input logic [sync_pkg::data_w-1:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per data bit
  task automatic next_random_word(output logic [sync_pkg::data_w-1:0] w);
    int i;
    w = '0;
    for (i = 0; i < sync_pkg::data_w; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[sync_pkg::data_w-2:0], lfsr[0]};
    end
  endtask

  task automatic add_row(input op_e op, input logic rnd,
                         input logic [sync_pkg::data_w-1:0] d0,
                         input logic [sync_pkg::data_w-1:0] d1,
                         input logic [1:0] takes, input logic full_exp);
    row_t r;
    r = '{op, rnd, d0, d1, takes, full_exp};
    table_q.push_back(r);
  endtask

  // Replays the slot at transaction level until no waiting client can move
  task automatic resolve_model();
    logic win;
    logic moved;
    moved = 1'b1;
    while (moved) begin
      moved = 1'b0;
      if (!m_full && pend_put != 2'b00) begin
        // Contention goes to the arbiter bit, which then flips
        win = (pend_put == 2'b11) ? m_arb_w : pend_put[1];
        if (pend_put == 2'b11) begin
          m_arb_w = !m_arb_w;
        end
        m_word = pend_data[win];
        m_full = 1'b1;
        pend_put[win] = 1'b0;
        put_done[win] = 1'b1;
        moved = 1'b1;
      end else if (m_full && pend_take != 2'b00) begin
        win = (pend_take == 2'b11) ? m_arb_r : pend_take[1];
        if (pend_take == 2'b11) begin
          m_arb_r = !m_arb_r;
        end
        if (win) begin
          exp_q1.push_back(m_word);
        end else begin
          exp_q0.push_back(m_word);
        end
        m_full = 1'b0;
        pend_take[win] = 1'b0;
        moved = 1'b1;
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    logic [1:0] puts;
    logic [1:0] takes;
    logic [1:0] exp_put_ready;
    logic [1:0] exp_take_ready;
    int         n;
    puts  = {r.op inside {op_put_1, op_put_both}, r.op inside {op_put_0, op_put_both}};
    takes = {r.op inside {op_take_1, op_take_both}, r.op inside {op_take_0, op_take_both}};
    @(posedge clk);
    #2;
    put_done  = 2'b00;
    got_takes = 2'b00;
    for (n = 0; n < 2; n++) begin
      if (puts[n]) begin
        check_value(put_ready[n], 1'b1, "put port idle before strobe");
        if (r.rnd) begin
          next_random_word(pend_data[n]);
        end else begin
          pend_data[n] = n ? r.d1 : r.d0;
        end
        put_data[n] = pend_data[n];
        pend_put[n] = 1'b1;
      end
      if (takes[n]) begin
        check_value(take_ready[n], 1'b1, "take port idle before strobe");
        pend_take[n] = 1'b1;
      end
    end
    resolve_model();
    put_valid = puts;
    take_req  = takes;
    @(posedge clk);
    #2;
    put_valid = 2'b00;
    take_req  = 2'b00;
    // Finished puts show ready again and finished takes have drained their queue
    while ((put_ready & put_done) != put_done || exp_q0.size() != 0 || exp_q1.size() != 0) begin
      @(negedge clk);
    end
    // A few quiet cycles in which the monitor catches any stray pulse
    repeat (3) @(negedge clk);
    exp_put_ready  = ~pend_put;
    exp_take_ready = ~pend_take;
    check_value(got_takes, r.takes, "take ports served in row");
    check_value(put_ready, exp_put_ready, "put_ready levels");
    check_value(take_ready, exp_take_ready, "take_ready levels");
    check_value(full, r.full, "full");
  endtask

  // Every take_valid pulse must carry the next expected word of its port
  always @(negedge clk) begin
    if (!reset && take_valid[0]) begin
      got_takes[0] = 1'b1;
      check_value(exp_q0.size() != 0, 1'b1, "take_valid_0 with a word pending");
      check_value(take_data[0], exp_q0.pop_front(), "take_data_0");
    end
    if (!reset && take_valid[1]) begin
      got_takes[1] = 1'b1;
      check_value(exp_q1.size() != 0, 1'b1, "take_valid_1 with a word pending");
      check_value(take_data[1], exp_q1.pop_front(), "take_data_1");
    end
  end

  initial begin
    // Twenty 20 ns cycles per row once the table is built at time 0
    #1;
    #(table_q.size() * 20 * 20);
    $display("ERROR: run timed out waiting for a ready or valid at %0t", $time);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int i;
    reset       = 1'b1;
    put_valid   = 2'b00;
    take_req    = 2'b00;
    put_data[0] = '0;
    put_data[1] = '0;
    lfsr        = 16'd16203;
    m_full      = 1'b0;
    m_word      = '0;
    m_arb_w     = 1'b0;
    m_arb_r     = 1'b0;
    pend_put    = 2'b00;
    pend_take   = 2'b00;
    put_done    = 2'b00;
    got_takes   = 2'b00;
    // Put followed by a take on the other port
    add_row(op_put_0, 1'b0, 32'hA5A5_0001, '0, 2'b00, 1'b1);
    add_row(op_take_1, 1'b0, '0, '0, 2'b10, 1'b0);
    // Second put blocks on full until a take
    add_row(op_put_0, 1'b0, 32'h1111_0001, '0, 2'b00, 1'b1);
    add_row(op_put_1, 1'b0, '0, 32'h2222_0002, 2'b00, 1'b1);
    add_row(op_take_0, 1'b0, '0, '0, 2'b01, 1'b1);
    add_row(op_take_1, 1'b0, '0, '0, 2'b10, 1'b0);
    // Write contention with port 0 winning first and port 1 winning next
    add_row(op_put_both, 1'b0, 32'h3333_0000, 32'h4444_0000, 2'b00, 1'b1);
    add_row(op_take_0, 1'b0, '0, '0, 2'b01, 1'b1);
    add_row(op_take_0, 1'b0, '0, '0, 2'b01, 1'b0);
    add_row(op_put_both, 1'b0, 32'h5555_0000, 32'h6666_0000, 2'b00, 1'b1);
    add_row(op_take_1, 1'b0, '0, '0, 2'b10, 1'b1);
    add_row(op_take_1, 1'b0, '0, '0, 2'b10, 1'b0);
    // Read contention where the loser waits on the empty slot
    add_row(op_put_0, 1'b0, 32'h7777_0000, '0, 2'b00, 1'b1);
    add_row(op_take_both, 1'b0, '0, '0, 2'b01, 1'b0);
    add_row(op_put_1, 1'b0, '0, 32'h8888_0000, 2'b10, 1'b0);
    add_row(op_put_0, 1'b0, 32'h9999_0000, '0, 2'b00, 1'b1);
    add_row(op_take_both, 1'b0, '0, '0, 2'b10, 1'b0);
    add_row(op_put_1, 1'b0, '0, 32'hAAAA_0000, 2'b01, 1'b0);
    // LFSR words through alternating ports
    for (i = 0; i < 8; i++) begin
      add_row(i % 2 ? op_put_1 : op_put_0, 1'b1, '0, '0, 2'b00, 1'b1);
      add_row((i / 2) % 2 ? op_take_1 : op_take_0, 1'b0, '0, '0,
              (i / 2) % 2 ? 2'b10 : 2'b01, 1'b0);
    end
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    check_value(put_ready, 2'b11, "put_ready after reset");
    check_value(take_ready, 2'b11, "take_ready after reset");
    check_value(take_valid, 2'b00, "take_valid after reset");
    check_value(full, 1'b0, "full after reset");
    foreach (table_q[k]) begin
      apply_row(table_q[k]);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* src.f */
design/sync_pkg.sv
design/sync_reg.sv
design/sync_put_port.sv
design/sync_take_port.sv
design/sync_exchange_top.sv
dv/tb_sync_exchange.sv
